// File: Bender.yml
package:
  name: core_exec

sources:
  - source/core_pkg.sv
  - source/core_decode.sv
  - source/core_alu.sv
  - source/core_mul.sv
  - source/core_control_cycle.sv
  - source/core_control_writeback.sv
  - source/core_regfile.sv
  - source/core_exec_top.sv
  - target: test
    files:
      - verification/core_exec_chk.sv
      - verification/core_exec_tb.sv

// File: source/core_alu.sv
`timescale 1ns/1ns
`default_nettype none

module core_alu (
	input  core_pkg::alu_op    op,
	input  core_pkg::word      a,
	input  core_pkg::word      b,
	input  core_pkg::psr_flags carry_in_flags,
	output core_pkg::word      q,
	output core_pkg::psr_flags flags
);

	import core_pkg::*;

	logic [32:0] sum;
	logic        c;
	logic        v;

	always_comb begin
		// logical ops keep c and v
		c = carry_in_flags[FLAG_C];
		v = carry_in_flags[FLAG_V];
		sum = '0;
		q = b;

		case (op)
			ADD: begin
				sum = {1'b0, a} + {1'b0, b};
				q = sum[31:0];
				c = sum[32];
				v = (a[31] == b[31]) && (q[31] != a[31]);
			end
			SUB: begin
				// carry out here is not-borrow
				sum = {1'b0, a} + {1'b0, ~b} + 33'd1;
				q = sum[31:0];
				c = sum[32];
				v = (a[31] != b[31]) && (q[31] != a[31]);
			end
			AND: q = a & b;
			ORR: q = a | b;
			default: q = b;
		endcase

		flags[FLAG_N] = q[31];
		flags[FLAG_Z] = (q == '0);
		flags[FLAG_C] = c;
		flags[FLAG_V] = v;
	end

endmodule

`default_nettype wire

// File: source/core_control_cycle.sv
`timescale 1ns/1ns
`default_nettype none

module core_control_cycle #(
	parameter core_pkg::word reset_pc = 32'h0000_0000,
	parameter core_pkg::word swi_vector = 32'h0000_0008,
	parameter core_pkg::word undef_vector = 32'h0000_0004
) (
	input  logic                clk,
	input  logic                rst,
	output logic                insn_req,
	input  logic                insn_ack,
	input  core_pkg::word       insn,
	output core_pkg::word       insn_q,
	output logic                mem_req,
	output logic                mem_write,
	input  logic                mem_ack,
	output core_pkg::word       mem_addr,
	output core_pkg::word       mem_wdata,
	input  logic                w,
	input  logic                is_load,
	input  logic                is_store,
	input  logic                is_mul,
	input  logic                is_exc,
	input  logic                vector_sel,
	input  core_pkg::word       base_sum,
	input  core_pkg::word       store_data,
	output core_pkg::ctrl_cycle cycle,
	output core_pkg::ctrl_cycle next_cycle,
	output logic                issue,
	output logic                mem_ready,
	output core_pkg::word       saved_base,
	output core_pkg::word       vector,
	output core_pkg::word       pc,
	output logic                mul_start,
	input  logic                mul_done
);

	import core_pkg::*;

	logic xfer_done;
	logic exc_ret;
	logic fetch_done;
	logic xfer_start;

	// second pass through ISSUE after an exception writes r14
	assign issue = (cycle == ISSUE) && !exc_ret;
	assign fetch_done = (cycle == FETCH) && insn_req && insn_ack;
	assign xfer_start = (cycle == TRANSFER) && !mem_req && !mem_ack && !xfer_done;
	assign mem_ready = (cycle == TRANSFER) && mem_req && mem_ack;
	assign mem_addr = saved_base;
	assign mul_start = issue && is_mul;

	always_comb begin
		next_cycle = cycle;
		case (cycle)
			FETCH:
				if (fetch_done)
					next_cycle = ISSUE;
			ISSUE:
				if (!issue)
					next_cycle = FETCH;
				else if (is_exc)
					next_cycle = EXCEPTION;
				else if (is_mul)
					next_cycle = MUL;
				else if (is_load || is_store)
					next_cycle = TRANSFER;
				else
					next_cycle = FETCH;
			// wait for ack to fall before moving on
			TRANSFER:
				if (xfer_done && !mem_ack)
					next_cycle = w ? BASE_WRITEBACK : FETCH;
			MUL:
				if (mul_done)
					next_cycle = MUL_HI_WB;
			EXCEPTION: next_cycle = ISSUE;
			default: next_cycle = FETCH;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cycle <= FETCH;
			pc <= reset_pc;
			insn_req <= 1'b0;
			mem_req <= 1'b0;
			xfer_done <= 1'b0;
			exc_ret <= 1'b0;
		end else begin
			cycle <= next_cycle;
			exc_ret <= (cycle == EXCEPTION);
			if (cycle == FETCH && !insn_req && !insn_ack)
				insn_req <= 1'b1;
			if (fetch_done) begin
				insn_req <= 1'b0;
				pc <= pc + 32'd4;
			end
			if (xfer_start)
				mem_req <= 1'b1;
			if (mem_ready) begin
				mem_req <= 1'b0;
				xfer_done <= 1'b1;
			end else if (xfer_done && !mem_ack) begin
				xfer_done <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_done)
			insn_q <= insn;
		if (issue && is_exc)
			vector <= vector_sel ? swi_vector : undef_vector;
		// address and data held for the whole handshake
		if (xfer_start) begin
			saved_base <= base_sum;
			mem_write <= is_store;
			mem_wdata <= store_data;
		end
	end

endmodule

`default_nettype wire

// File: source/core_control_writeback.sv
`timescale 1ns/1ns
`default_nettype none

module core_control_writeback (
	input  logic                clk,
	input  logic                rst,
	input  core_pkg::ctrl_cycle cycle,
	input  core_pkg::ctrl_cycle next_cycle,
	input  logic                issue,
	input  logic                s,
	input  logic                is_alu,
	input  logic                w,
	input  logic                is_store,
	input  logic                mem_ready,
	input  core_pkg::reg_num    dec_rd,
	input  core_pkg::reg_num    ra,
	input  core_pkg::reg_num    rhi,
	input  core_pkg::word       q_alu,
	input  core_pkg::word       mem_data_rd,
	input  core_pkg::word       saved_base,
	input  core_pkg::word       vector,
	input  core_pkg::word       mul_q_hi,
	input  core_pkg::word       mul_q_lo,
	input  core_pkg::psr_flags  alu_flags,
	output core_pkg::reg_num    rd,
	output logic                writeback,
	output logic                update_flags,
	output core_pkg::word       wr_value,
	output core_pkg::psr_flags  wb_alu_flags
);

	import core_pkg::*;

	reg_num final_rd;
	logic   final_writeback;
	logic   final_update_flags;

	// flags land one cycle after the alu write
	assign update_flags = final_update_flags;

	always_comb begin
		rd = dec_rd;
		writeback = 1'b0;
		wr_value = q_alu;

		case (cycle)
			ISSUE:
				if (issue) begin
					writeback = is_alu;
				end else begin
					// return address, alu passes pc through
					rd = final_rd;
					writeback = final_writeback;
				end
			TRANSFER: begin
				rd = final_rd;
				wr_value = mem_data_rd;
				writeback = mem_ready && final_writeback;
			end
			BASE_WRITEBACK: begin
				rd = ra;
				wr_value = saved_base;
				writeback = w;
			end
			MUL: begin
				rd = final_rd;
				wr_value = mul_q_lo;
				writeback = (next_cycle == MUL_HI_WB) && final_writeback;
			end
			MUL_HI_WB: begin
				rd = rhi;
				wr_value = mul_q_hi;
				writeback = 1'b1;
			end
			EXCEPTION: begin
				rd = R15;
				wr_value = vector;
				writeback = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			final_rd <= '0;
			final_writeback <= 1'b0;
			final_update_flags <= 1'b0;
		end else begin
			final_update_flags <= (cycle == ISSUE) && issue && is_alu && s;
			case (next_cycle)
				TRANSFER, MUL:
					if (cycle == ISSUE) begin
						final_rd <= dec_rd;
						// stores only write the base
						final_writeback <= !is_store;
					end
				EXCEPTION: begin
					final_rd <= R14;
					final_writeback <= 1'b1;
				end
				FETCH: final_writeback <= 1'b0;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		wb_alu_flags <= alu_flags;
	end

endmodule

`default_nettype wire

// File: source/core_decode.sv
`timescale 1ns/1ns
`default_nettype none

module core_decode (
	input  core_pkg::word    insn,
	output logic [3:0]       op,
	output core_pkg::alu_op  alu,
	output logic             s,
	output logic             w,
	output logic             is_alu,
	output logic             is_load,
	output logic             is_store,
	output logic             is_mul,
	output logic             is_exc,
	output core_pkg::reg_num rd,
	output core_pkg::reg_num ra,
	output core_pkg::reg_num rb,
	output core_pkg::reg_num rhi,
	output core_pkg::word    imm,
	output logic             vector_sel
);

	import core_pkg::*;

	always_comb begin
		op = insn[OP_LSB +: 4];
		s = insn[S_BIT];
		w = insn[W_BIT];
		rd = insn[RD_LSB +: 4];
		ra = insn[RA_LSB +: 4];
		rb = insn[RB_LSB +: 4];
		// mul high half destination sits in the low imm bits
		rhi = insn[RHI_LSB +: 4];
		imm = {{(32 - IMM_W){1'b0}}, insn[IMM_W-1:0]};

		alu = ADD;
		is_alu = 1'b0;
		is_load = 1'b0;
		is_store = 1'b0;
		is_mul = 1'b0;
		is_exc = 1'b0;
		vector_sel = 1'b0;

		case (op)
			OP_ADD: begin
				is_alu = 1'b1;
				alu = ADD;
			end
			OP_SUB: begin
				is_alu = 1'b1;
				alu = SUB;
			end
			OP_AND: begin
				is_alu = 1'b1;
				alu = AND;
			end
			OP_ORR: begin
				is_alu = 1'b1;
				alu = ORR;
			end
			OP_MOVI: begin
				is_alu = 1'b1;
				alu = MOV;
			end
			OP_LDR: is_load = 1'b1;
			OP_STR: is_store = 1'b1;
			OP_MUL: is_mul = 1'b1;
			OP_SWI: begin
				is_exc = 1'b1;
				vector_sel = 1'b1;
			end
			// undefined opcode
			default: is_exc = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// File: source/core_exec_top.sv
`timescale 1ns/1ns
`default_nettype none

module core_exec_top #(
	parameter core_pkg::word reset_pc = 32'h0000_0000,
	parameter core_pkg::word swi_vector = 32'h0000_0008,
	parameter core_pkg::word undef_vector = 32'h0000_0004
) (
	input  logic               clk,
	input  logic               rst,
	output logic               insn_req,
	input  logic               insn_ack,
	input  core_pkg::word      insn,
	output logic               mem_req,
	output logic               mem_write,
	input  logic               mem_ack,
	output core_pkg::word      mem_addr,
	output core_pkg::word      mem_wdata,
	input  core_pkg::word      mem_rdata,
	output logic               wb_valid,
	output core_pkg::reg_num   wb_rd,
	output core_pkg::word      wb_value,
	output core_pkg::psr_flags flags
);

	import core_pkg::*;

	word        insn_q;
	word        imm;
	word        rdata_a;
	word        rdata_b;
	word        alu_b;
	word        q_alu;
	word        saved_base;
	word        vector;
	word        pc;
	word        mul_q_hi;
	word        mul_q_lo;
	logic [3:0] op;
	alu_op      dec_alu;
	alu_op      alu_sel;
	logic       s;
	logic       w;
	logic       is_alu;
	logic       is_load;
	logic       is_store;
	logic       is_mul;
	logic       is_exc;
	logic       vector_sel;
	reg_num     dec_rd;
	reg_num     ra;
	reg_num     rb;
	reg_num     rhi;
	reg_num     raddr_b;
	ctrl_cycle  cycle;
	ctrl_cycle  next_cycle;
	logic       issue;
	logic       mem_ready;
	logic       mul_start;
	logic       mul_done;
	logic       update_flags;
	psr_flags   alu_flags;
	psr_flags   wb_alu_flags;

	// stores read their data register on port b
	assign raddr_b = is_store ? dec_rd : rb;

	// address add in TRANSFER, pc pass-through on exception return
	assign alu_sel = (cycle == TRANSFER) ? ADD : (issue ? dec_alu : MOV);
	assign alu_b = (cycle == TRANSFER) ? imm :
		(!issue ? pc : ((op == OP_MOVI) ? imm : rdata_b));

	core_decode decode_i (
		.insn      (insn_q),
		.op        (op),
		.alu       (dec_alu),
		.s         (s),
		.w         (w),
		.is_alu    (is_alu),
		.is_load   (is_load),
		.is_store  (is_store),
		.is_mul    (is_mul),
		.is_exc    (is_exc),
		.rd        (dec_rd),
		.ra        (ra),
		.rb        (rb),
		.rhi       (rhi),
		.imm       (imm),
		.vector_sel(vector_sel)
	);

	core_alu alu_i (
		.op            (alu_sel),
		.a             (rdata_a),
		.b             (alu_b),
		.carry_in_flags(flags),
		.q             (q_alu),
		.flags         (alu_flags)
	);

	core_mul mul_i (
		.clk  (clk),
		.rst  (rst),
		.start(mul_start),
		.a    (rdata_a),
		.b    (rdata_b),
		.busy (),
		.done (mul_done),
		.q_hi (mul_q_hi),
		.q_lo (mul_q_lo)
	);

	core_control_cycle #(
		.reset_pc    (reset_pc),
		.swi_vector  (swi_vector),
		.undef_vector(undef_vector)
	) control_cycle_i (
		.clk       (clk),
		.rst       (rst),
		.insn_req  (insn_req),
		.insn_ack  (insn_ack),
		.insn      (insn),
		.insn_q    (insn_q),
		.mem_req   (mem_req),
		.mem_write (mem_write),
		.mem_ack   (mem_ack),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.w         (w),
		.is_load   (is_load),
		.is_store  (is_store),
		.is_mul    (is_mul),
		.is_exc    (is_exc),
		.vector_sel(vector_sel),
		.base_sum  (q_alu),
		.store_data(rdata_b),
		.cycle     (cycle),
		.next_cycle(next_cycle),
		.issue     (issue),
		.mem_ready (mem_ready),
		.saved_base(saved_base),
		.vector    (vector),
		.pc        (pc),
		.mul_start (mul_start),
		.mul_done  (mul_done)
	);

	core_control_writeback control_writeback_i (
		.clk         (clk),
		.rst         (rst),
		.cycle       (cycle),
		.next_cycle  (next_cycle),
		.issue       (issue),
		.s           (s),
		.is_alu      (is_alu),
		.w           (w),
		.is_store    (is_store),
		.mem_ready   (mem_ready),
		.dec_rd      (dec_rd),
		.ra          (ra),
		.rhi         (rhi),
		.q_alu       (q_alu),
		.mem_data_rd (mem_rdata),
		.saved_base  (saved_base),
		.vector      (vector),
		.mul_q_hi    (mul_q_hi),
		.mul_q_lo    (mul_q_lo),
		.alu_flags   (alu_flags),
		.rd          (wb_rd),
		.writeback   (wb_valid),
		.update_flags(update_flags),
		.wr_value    (wb_value),
		.wb_alu_flags(wb_alu_flags)
	);

	core_regfile regfile_i (
		.clk     (clk),
		.rst     (rst),
		.raddr_a (ra),
		.raddr_b (raddr_b),
		.rdata_a (rdata_a),
		.rdata_b (rdata_b),
		.we      (wb_valid),
		.waddr   (wb_rd),
		.wdata   (wb_value),
		.flags_we(update_flags),
		.flags_in(wb_alu_flags),
		.flags   (flags)
	);

endmodule

`default_nettype wire

// File: source/core_mul.sv
`timescale 1ns/1ns
`default_nettype none

module core_mul (
	input  logic          clk,
	input  logic          rst,
	input  logic          start,
	input  core_pkg::word a,
	input  core_pkg::word b,
	output logic          busy,
	output logic          done,
	output core_pkg::word q_hi,
	output core_pkg::word q_lo
);

	import core_pkg::*;

	localparam logic [3:0] DIGITS = 4'd8;

	logic [63:0] acc;
	logic [63:0] mcand;
	word         mplier;
	logic [3:0]  count;

	assign q_hi = acc[63:32];
	assign q_lo = acc[31:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
			count <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				count <= DIGITS;
			end else if (busy) begin
				count <= count - 4'd1;
				if (count == 4'd1) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// one radix-16 digit of b per cycle
	always_ff @(posedge clk) begin
		if (start) begin
			acc <= '0;
			mcand <= {32'b0, a};
			mplier <= b;
		end else if (busy) begin
			acc <= acc + mcand * 64'(mplier[3:0]);
			mcand <= mcand << 4;
			mplier <= mplier >> 4;
		end
	end

endmodule

`default_nettype wire

// File: source/core_pkg.sv
`default_nettype none

package core_pkg;

	typedef logic [31:0] word;
	typedef logic [3:0] reg_num;
	// n z c v, msb first
	typedef logic [3:0] psr_flags;

	typedef enum logic [2:0] {
		FETCH,
		ISSUE,
		TRANSFER,
		BASE_WRITEBACK,
		MUL,
		MUL_HI_WB,
		EXCEPTION
	} ctrl_cycle;

	typedef enum logic [2:0] {
		ADD,
		SUB,
		AND,
		ORR,
		MOV
	} alu_op;

	localparam logic [3:0] OP_ADD = 4'd0;
	localparam logic [3:0] OP_SUB = 4'd1;
	localparam logic [3:0] OP_AND = 4'd2;
	localparam logic [3:0] OP_ORR = 4'd3;
	localparam logic [3:0] OP_MOVI = 4'd4;
	localparam logic [3:0] OP_LDR = 4'd5;
	localparam logic [3:0] OP_STR = 4'd6;
	localparam logic [3:0] OP_MUL = 4'd7;
	localparam logic [3:0] OP_SWI = 4'd8;

	// instruction fields
	localparam int OP_LSB = 28;
	localparam int S_BIT = 27;
	localparam int W_BIT = 26;
	localparam int RD_LSB = 20;
	localparam int RA_LSB = 16;
	localparam int RB_LSB = 12;
	localparam int IMM_W = 12;
	localparam int RHI_LSB = 0;

	localparam int FLAG_N = 3;
	localparam int FLAG_Z = 2;
	localparam int FLAG_C = 1;
	localparam int FLAG_V = 0;

	localparam reg_num R14 = 4'd14;
	localparam reg_num R15 = 4'd15;

endpackage

`default_nettype wire

// File: source/core_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module core_regfile (
	input  logic               clk,
	input  logic               rst,
	input  core_pkg::reg_num   raddr_a,
	input  core_pkg::reg_num   raddr_b,
	output core_pkg::word      rdata_a,
	output core_pkg::word      rdata_b,
	input  logic               we,
	input  core_pkg::reg_num   waddr,
	input  core_pkg::word      wdata,
	input  logic               flags_we,
	input  core_pkg::psr_flags flags_in,
	output core_pkg::psr_flags flags
);

	import core_pkg::*;

	word regs [16];

	// reads are never in flight with a write to the same register
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
			flags <= '0;
		end else begin
			if (we)
				regs[waddr] <= wdata;
			if (flags_we)
				flags <= flags_in;
		end
	end

endmodule

`default_nettype wire

// File: sources.f
source/core_pkg.sv
source/core_decode.sv
source/core_alu.sv
source/core_mul.sv
source/core_control_cycle.sv
source/core_control_writeback.sv
source/core_regfile.sv
source/core_exec_top.sv
verification/core_exec_chk.sv
verification/core_exec_tb.sv

// File: verification/core_exec_chk.sv
`timescale 1ns/1ns
`default_nettype none

module core_exec_chk (
	input logic                clk,
	input logic                rst,
	input logic                insn_req,
	input logic                insn_ack,
	input logic                mem_req,
	input logic                mem_ack,
	input core_pkg::word       mem_addr,
	input logic                wb_valid,
	input core_pkg::ctrl_cycle cycle
);

	import core_pkg::*;

	int unsigned fails = 0;
	logic        armed = 1'b0;

	// set once reset has been seen on an earlier edge
	always @(posedge clk) begin
		armed <= rst;
	end

	insn_req_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(insn_req) |-> !$past(insn_ack))
	else begin
		fails++;
		$error("insn_req rose while insn_ack was still high");
	end

	mem_req_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(mem_req) |-> !$past(mem_ack))
	else begin
		fails++;
		$error("mem_req rose while mem_ack was still high");
	end

	mem_addr_stable: assert property (@(posedge clk) disable iff (rst)
		mem_req && $past(mem_req) |-> $stable(mem_addr))
	else begin
		fails++;
		$error("mem_addr changed during a memory request");
	end

	no_write_in_reset: assert property (@(posedge clk)
		armed && rst |-> !wb_valid)
	else begin
		fails++;
		$error("wb_valid high during reset");
	end

	// high half directly after the low half
	mul_hi_follows_lo: assert property (@(posedge clk) disable iff (rst)
		wb_valid && cycle == MUL_HI_WB |-> $past(wb_valid))
	else begin
		fails++;
		$error("multiply high half not written right after the low half");
	end

endmodule

bind core_exec_top core_exec_chk chk_i (
	.clk     (clk),
	.rst     (rst),
	.insn_req(insn_req),
	.insn_ack(insn_ack),
	.mem_req (mem_req),
	.mem_ack (mem_ack),
	.mem_addr(mem_addr),
	.wb_valid(wb_valid),
	.cycle   (cycle)
);

`default_nettype wire

// File: verification/core_exec_tb.sv
`timescale 1ns/1ns
`default_nettype none

module core_exec_tb;

	import core_pkg::*;

	localparam word reset_pc_val = 32'h0000_0100;
	localparam word swi_vec = 32'h0000_0008;
	localparam word undef_vec = 32'h0000_0004;

	logic     clk;
	logic     rst = 1'b1;
	logic     insn_req;
	logic     insn_ack = 1'b0;
	word      insn = '0;
	logic     mem_req;
	logic     mem_write;
	logic     mem_ack = 1'b0;
	word      mem_addr;
	word      mem_wdata;
	word      mem_rdata = '0;
	logic     wb_valid;
	reg_num   wb_rd;
	word      wb_value;
	psr_flags flags;

	integer seed = 32'h18191f96;
	int     errors = 0;
	int     checks = 0;
	int     tests = 0;
	int     cycles = 0;
	int     issued = 0;
	int     insn_wait = 0;
	int     mem_wait = 0;

	word      mem [256];
	word      model_mem [256];
	word      model_regs [16];
	psr_flags model_flags;
	word      model_pc;

	// pending instructions and the flags expected when each is fetched
	word      insn_fifo [$];
	psr_flags flags_fifo [$];
	reg_num   exp_rd_q [$];
	word      exp_val_q [$];

	// memory accesses expected in issue order
	logic     exp_write_q [$];
	word      exp_addr_q [$];
	word      exp_wdata_q [$];

	core_exec_top #(
		.reset_pc    (reset_pc_val),
		.swi_vector  (swi_vec),
		.undef_vector(undef_vec)
	) dut_i (
		.clk      (clk),
		.rst      (rst),
		.insn_req (insn_req),
		.insn_ack (insn_ack),
		.insn     (insn),
		.mem_req  (mem_req),
		.mem_write(mem_write),
		.mem_ack  (mem_ack),
		.mem_addr (mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.wb_value (wb_value),
		.flags    (flags)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic word fill_word(input int unsigned idx);
		return (idx * 32'h9e37_79b1) ^ 32'h0bad_f00d ^ (idx << 24);
	endfunction

	function automatic word make_insn(input logic [3:0] op, input logic s, input logic w,
		input reg_num rd, input reg_num ra, input reg_num rb, input logic [11:0] imm);
		return {op, s, w, 2'b00, rd, ra, rb, imm};
	endfunction

	task automatic check_word(input string name, input word got, input word exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_reg(input string name, input reg_num got, input reg_num exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s got r%0d expected r%0d", $time, name, got, exp);
		end
	endtask

	task automatic check_flags(input string name, input psr_flags got, input psr_flags exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic record(input reg_num rd, input word value);
		exp_rd_q.push_back(rd);
		exp_val_q.push_back(value);
		model_regs[rd] = value;
	endtask

	task automatic expect_access(input logic write, input word addr, input word data);
		exp_write_q.push_back(write);
		exp_addr_q.push_back(addr);
		exp_wdata_q.push_back(data);
	endtask

	// reference model, one instruction at a time
	task automatic exec_model(input word i);
		logic [3:0]  op;
		reg_num      rd;
		reg_num      ra;
		word         a;
		word         b;
		word         q;
		word         imm;
		word         addr;
		logic [32:0] wide;
		logic [63:0] prod;
		logic        c;
		logic        v;

		op = i[31:28];
		rd = i[23:20];
		ra = i[19:16];
		imm = {20'b0, i[11:0]};
		a = model_regs[ra];
		b = (op == OP_MOVI) ? imm : model_regs[i[15:12]];
		c = model_flags[FLAG_C];
		v = model_flags[FLAG_V];
		model_pc = model_pc + 32'd4;

		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_MOVI: begin
				if (op == OP_ADD) begin
					wide = {1'b0, a} + {1'b0, b};
					q = wide[31:0];
					c = wide[32];
					v = (a[31] & b[31] & ~q[31]) | (~a[31] & ~b[31] & q[31]);
				end else if (op == OP_SUB) begin
					q = a - b;
					c = (a >= b);
					v = (a[31] & ~b[31] & ~q[31]) | (~a[31] & b[31] & q[31]);
				end else if (op == OP_AND) begin
					q = a & b;
				end else if (op == OP_ORR) begin
					q = a | b;
				end else begin
					q = imm;
				end
				record(rd, q);
				if (i[27])
					model_flags = {q[31], q == 32'd0, c, v};
			end
			OP_LDR: begin
				addr = a + imm;
				expect_access(1'b0, addr, '0);
				record(rd, model_mem[addr[9:2]]);
				if (i[26])
					record(ra, addr);
			end
			OP_STR: begin
				addr = a + imm;
				expect_access(1'b1, addr, model_regs[rd]);
				model_mem[addr[9:2]] = model_regs[rd];
				if (i[26])
					record(ra, addr);
			end
			OP_MUL: begin
				prod = {32'b0, a} * {32'b0, b};
				record(rd, prod[31:0]);
				record(i[3:0], prod[63:32]);
			end
			default: begin
				record(R15, (op == OP_SWI) ? swi_vec : undef_vec);
				// model_pc already points past the faulting instruction
				record(R14, model_pc);
			end
		endcase
	endtask

	task automatic send_insn(input word i);
		insn_fifo.push_back(i);
		flags_fifo.push_back(model_flags);
		exec_model(i);
	endtask

	task automatic check_access();
		logic exp_write;
		word  exp_data;

		if (exp_addr_q.size() == 0) begin
			errors++;
			$display("Error at %0t: memory request when no access was expected", $time);
		end else begin
			exp_write = exp_write_q.pop_front();
			exp_data = exp_wdata_q.pop_front();
			check_bit("mem_write", mem_write, exp_write);
			check_word("mem_addr", mem_addr, exp_addr_q.pop_front());
			if (exp_write)
				check_word("mem_wdata", mem_wdata, exp_data);
		end
	endtask

	// wait until the core is back in FETCH with nothing left to write
	task automatic drain();
		do
			@(negedge clk);
		while (insn_fifo.size() != 0 || exp_rd_q.size() != 0 || exp_addr_q.size() != 0 ||
			!insn_req || insn_ack);
		check_flags("flags", flags, model_flags);
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests++;
		if (errors == start_errors)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - start_errors);
	endtask

	task automatic test_alu();
		int start_errors;

		start_errors = errors;
		send_insn(make_insn(OP_MOVI, 1'b1, 1'b0, 4'd1, 4'd0, 4'd0, 12'hfff));
		// zero minus positive borrows
		send_insn(make_insn(OP_SUB, 1'b1, 1'b0, 4'd2, 4'd0, 4'd1, 12'h000));
		send_insn(make_insn(OP_ADD, 1'b1, 1'b0, 4'd3, 4'd2, 4'd2, 12'h000));
		send_insn(make_insn(OP_MOVI, 1'b0, 1'b0, 4'd6, 4'd0, 4'd0, 12'h800));
		send_insn(make_insn(OP_MUL, 1'b0, 1'b0, 4'd7, 4'd6, 4'd6, 12'h008));
		send_insn(make_insn(OP_MOVI, 1'b0, 1'b0, 4'd9, 4'd0, 4'd0, 12'h200));
		// r7 becomes 0x8000_0000
		send_insn(make_insn(OP_MUL, 1'b0, 1'b0, 4'd7, 4'd7, 4'd9, 12'h008));
		send_insn(make_insn(OP_SUB, 1'b1, 1'b0, 4'd10, 4'd7, 4'd1, 12'h000));
		send_insn(make_insn(OP_ADD, 1'b1, 1'b0, 4'd11, 4'd7, 4'd7, 12'h000));
		send_insn(make_insn(OP_AND, 1'b0, 1'b0, 4'd12, 4'd1, 4'd2, 12'h000));
		send_insn(make_insn(OP_ORR, 1'b1, 1'b0, 4'd13, 4'd1, 4'd2, 12'h000));
		send_insn(make_insn(OP_ADD, 1'b0, 1'b0, 4'd4, 4'd1, 4'd1, 12'h000));
		drain();
		report_test("alu", start_errors);
	endtask

	task automatic test_load_store();
		int          start_errors;
		int          k;
		logic [11:0] off;
		logic [11:0] val;

		start_errors = errors;
		send_insn(make_insn(OP_MOVI, 1'b0, 1'b0, 4'd1, 4'd0, 4'd0, 12'h040));
		send_insn(make_insn(OP_MOVI, 1'b0, 1'b0, 4'd2, 4'd0, 4'd0, 12'habc));
		send_insn(make_insn(OP_STR, 1'b0, 1'b0, 4'd2, 4'd1, 4'd0, 12'h008));
		send_insn(make_insn(OP_LDR, 1'b0, 1'b0, 4'd4, 4'd1, 4'd0, 12'h008));
		send_insn(make_insn(OP_STR, 1'b0, 1'b1, 4'd3, 4'd1, 4'd0, 12'h010));
		send_insn(make_insn(OP_LDR, 1'b0, 1'b1, 4'd5, 4'd1, 4'd0, 12'h000));
		// base lands last when data and base share a register
		send_insn(make_insn(OP_LDR, 1'b0, 1'b1, 4'd1, 4'd1, 4'd0, 12'h004));
		for (k = 0; k < 4; k++) begin
			off = 12'($random(seed)) & 12'h3fc;
			val = 12'($random(seed));
			send_insn(make_insn(OP_MOVI, 1'b0, 1'b0, 4'd2, 4'd0, 4'd0, val));
			send_insn(make_insn(OP_STR, 1'b0, 1'b0, 4'd2, 4'd1, 4'd0, off));
			send_insn(make_insn(OP_LDR, 1'b0, 1'b1, 4'd6, 4'd1, 4'd0, off));
		end
		drain();
		report_test("load_store", start_errors);
	endtask

	task automatic test_mul();
		int start_errors;
		int k;

		start_errors = errors;
		for (k = 0; k < 4; k++) begin
			send_insn(make_insn(OP_MOVI, 1'b0, 1'b0, 4'd1, 4'd0, 4'd0,
				12'($random(seed)) | 12'h001));
			send_insn(make_insn(OP_MOVI, 1'b0, 1'b0, 4'd2, 4'd0, 4'd0,
				12'($random(seed)) | 12'h001));
			send_insn(make_insn(OP_MOVI, 1'b0, 1'b0, 4'd3, 4'd0, 4'd0,
				12'($random(seed)) | 12'h001));
			send_insn(make_insn(OP_MUL, 1'b0, 1'b0, 4'd4, 4'd1, 4'd2, 12'h005));
			send_insn(make_insn(OP_MUL, 1'b0, 1'b0, 4'd6, 4'd4, 4'd3, 12'h005));
			// both operands wide, so the high half is busy
			send_insn(make_insn(OP_MUL, 1'b0, 1'b0, 4'd7, 4'd6, 4'd6, 12'h008));
			send_insn(make_insn(OP_MUL, 1'b0, 1'b0, 4'd9, 4'd7, 4'd6, 12'h00a));
		end
		drain();
		report_test("mul", start_errors);
	endtask

	task automatic test_exceptions();
		int start_errors;

		start_errors = errors;
		send_insn(make_insn(OP_SWI, 1'b0, 1'b0, 4'd0, 4'd0, 4'd0, 12'h000));
		send_insn(make_insn(OP_MOVI, 1'b0, 1'b0, 4'd3, 4'd0, 4'd0, 12'h123));
		send_insn(make_insn(4'hc, 1'b0, 1'b0, 4'd2, 4'd1, 4'd0, 12'h000));
		send_insn(make_insn(4'hf, 1'b1, 1'b1, 4'd5, 4'd6, 4'd7, 12'h456));
		drain();
		report_test("exceptions", start_errors);
	endtask

	task automatic test_mixed();
		int         start_errors;
		int         k;
		logic [3:0] op;
		word        raw;

		start_errors = errors;
		for (k = 0; k < 30; k++) begin
			op = 4'($random(seed) & 7);
			raw = $random(seed);
			send_insn({op, raw[27:0]});
		end
		drain();
		report_test("mixed", start_errors);
	endtask

	// instruction source
	always @(posedge clk) begin
		if (rst) begin
			insn_ack <= 1'b0;
		end else if (insn_ack) begin
			if (!insn_req)
				insn_ack <= 1'b0;
		end else if (insn_req && insn_fifo.size() != 0) begin
			if (insn_wait != 0) begin
				insn_wait <= insn_wait - 1;
			end else begin
				insn <= insn_fifo.pop_front();
				check_flags("flags", flags, flags_fifo.pop_front());
				issued++;
				insn_ack <= 1'b1;
				insn_wait <= $random(seed) & 3;
			end
		end
	end

	// memory responder indexed by mem_addr[9:2]
	always @(posedge clk) begin
		if (rst) begin
			mem_ack <= 1'b0;
		end else if (mem_ack) begin
			if (!mem_req)
				mem_ack <= 1'b0;
		end else if (mem_req) begin
			if (mem_wait != 0) begin
				mem_wait <= mem_wait - 1;
			end else begin
				check_access();
				if (mem_write)
					mem[mem_addr[9:2]] <= mem_wdata;
				else
					mem_rdata <= mem[mem_addr[9:2]];
				mem_ack <= 1'b1;
				mem_wait <= $random(seed) & 3;
			end
		end
	end

	// trace scoreboard
	always @(posedge clk) begin
		if (!rst && wb_valid) begin
			if (exp_rd_q.size() == 0) begin
				errors++;
				$display("Error at %0t: write to r%0d when no write was expected",
					$time, wb_rd);
			end else begin
				check_reg("wb_rd", wb_rd, exp_rd_q.pop_front());
				check_word("wb_value", wb_value, exp_val_q.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > 100 + 40 * issued) begin
			$display("Timeout: no progress after %0d cycles, %0d instructions issued",
				cycles, issued);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = fill_word(i);
			model_mem[i] = fill_word(i);
		end
		for (int i = 0; i < 16; i++) begin
			model_regs[i] = '0;
		end
		model_flags = '0;
		model_pc = reset_pc_val;

		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);

		test_alu();
		test_load_store();
		test_mul();
		test_exceptions();
		test_mixed();

		if (dut_i.chk_i.fails != 0) begin
			errors += dut_i.chk_i.fails;
			$display("Error: %0d assertion failures in the checker", dut_i.chk_i.fails);
		end
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
